// File: hw/cdcLinkPkg.sv
/* CDC link shared types */

`default_nettype none

package cdcLinkPkg;

    // ====================
    // Word layout
    // ====================
    typedef logic [11:0] payloadT;  // Data field
    typedef logic [3:0] tagT;       // Sequence or class, chosen by producer

    // Unit carried end to end, tag in the upper nibble
    typedef struct packed {
        tagT tag;
        payloadT payload;
    } linkWordT;

    localparam int wordBits = $bits(linkWordT);  // FIFO memory width

    // ====================
    // Read side handshake
    // ====================
    typedef enum logic [1:0] {
        hsIdle    = 2'b00,  // Waiting for a word in the FIFO
        hsPresent = 2'b01,  // outReq high, word held
        hsRelease = 2'b10   // outReq low, waiting for outAck to drop
    } hsStateT;

endpackage

`default_nettype wire

// File: hw/asyncFifo.sv
/* Dual clock FIFO, Gray pointers */

`timescale 1ns/100ps
`default_nettype none

module asyncFifo #(
    parameter int Depth = 8  // Power of two, at least 4
) (
    // Write domain
    input wire wclk,
    input wire arok,
    input wire push,
    input wire cdcLinkPkg::linkWordT pushWord,
    output logic full,
    // Read domain
    input wire rclk,
    input wire pop,
    output cdcLinkPkg::linkWordT headWord,
    output logic empty
);

    localparam int addrBits = $clog2(Depth);
    localparam int ptrBits = addrBits + 1;  // Extra wrap bit

    typedef logic [ptrBits-1:0] ptrT;
    typedef logic [addrBits-1:0] addrT;

    logic [cdcLinkPkg::wordBits-1:0] mem [Depth];  // Storage, no reset

    ptrT wBin, wGray, wBinNext, wGrayNext;
    ptrT rBin, rGray, rBinNext, rGrayNext;
    ptrT rGraySync1, rGraySync2;  // Read pointer seen in wclk domain
    ptrT wGraySync1, wGraySync2;  // Write pointer seen in rclk domain
    addrT wAddr, rAddr;

    // ====================
    // Write side
    // ====================
    assign wBinNext = wBin + ptrT'(push & ~full);   // Advance only when room
    assign wGrayNext = (wBinNext >> 1) ^ wBinNext;
    assign wAddr = wBin[addrBits-1:0];

    always_ff @(posedge wclk) begin
        if (push && !full) begin
            mem[wAddr] <= pushWord;
        end
    end

    always_ff @(posedge wclk or negedge arok) begin
        if (!arok) begin
            wBin <= '0;
            wGray <= '0;
            rGraySync1 <= '0;
            rGraySync2 <= '0;
            full <= 1'b0;
        end else begin
            wBin <= wBinNext;
            wGray <= wGrayNext;
            rGraySync1 <= rGray;       // First stage, may go metastable
            rGraySync2 <= rGraySync1;
            // Full when next write pointer laps the read pointer once
            full <= (wGrayNext == {~rGraySync2[ptrBits-1 -: 2],
                                   rGraySync2[ptrBits-3:0]});
        end
    end

    // ====================
    // Read side
    // ====================
    assign rBinNext = rBin + ptrT'(pop & ~empty);   // Never step past the writer
    assign rGrayNext = (rBinNext >> 1) ^ rBinNext;
    assign rAddr = rBin[addrBits-1:0];

    // Head of queue, combinational read
    assign headWord = cdcLinkPkg::linkWordT'(mem[rAddr]);

    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) begin
            rBin <= '0;
            rGray <= '0;
            wGraySync1 <= '0;
            wGraySync2 <= '0;
            empty <= 1'b1;  // Nothing stored after reset
        end else begin
            rBin <= rBinNext;
            rGray <= rGrayNext;
            wGraySync1 <= wGray;
            wGraySync2 <= wGraySync1;
            // Empty once the reader catches the synced writer
            empty <= (rGrayNext == wGraySync2);
        end
    end

endmodule

`default_nettype wire

// File: hw/writeAdapter.sv
/* Producer req/ack slave */

`timescale 1ns/100ps
`default_nettype none

module writeAdapter (
    input wire wclk,
    input wire arok,
    // Producer handshake
    input wire inReq,
    input wire cdcLinkPkg::linkWordT inWord,
    output logic inAck,
    // FIFO write port
    input wire full,
    output logic push,
    output cdcLinkPkg::linkWordT pushWord
);

    // ====================
    // Push decision
    // ====================
    // New request only while ack is still low
    // Full holds the ack back, producer keeps waiting
    assign push = inReq & ~inAck & ~full;

    // Word is stable for the whole request phase
    assign pushWord = inWord;

    // ====================
    // Acknowledge
    // ====================
    always_ff @(posedge wclk or negedge arok) begin
        if (!arok) begin
            inAck <= 1'b0;
        end else if (push) begin
            inAck <= 1'b1;      // Raised at the push edge
        end else if (!inReq) begin
            inAck <= 1'b0;      // Return to zero after request drops
        end
    end

    // One push per request follows from inAck gating push
    // Ack stays high until inReq falls

endmodule

`default_nettype wire

// File: hw/readAdapter.sv
/* Consumer req/ack master */

`timescale 1ns/100ps
`default_nettype none

module readAdapter (
    input wire rclk,
    input wire arok,
    // FIFO read port
    input wire empty,
    input wire cdcLinkPkg::linkWordT headWord,
    output logic pop,
    // Consumer handshake
    output logic outReq,
    output cdcLinkPkg::linkWordT outWord,
    input wire outAck
);

    cdcLinkPkg::hsStateT state;

    // ====================
    // Pop and present
    // ====================
    // Leave idle only when a word is waiting
    assign pop = (state == cdcLinkPkg::hsIdle) & ~empty;

    // Request follows the present state directly
    assign outReq = (state == cdcLinkPkg::hsPresent);

    // Held word
    always_ff @(posedge rclk) begin
        if (pop) begin
            outWord <= headWord;   // Captured with the pop
        end
    end

    // ====================
    // Handshake FSM
    // ====================
    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) begin
            state <= cdcLinkPkg::hsIdle;
        end else begin
            case (state)
                cdcLinkPkg::hsIdle: begin
                    if (pop) begin
                        state <= cdcLinkPkg::hsPresent;
                    end
                end
                cdcLinkPkg::hsPresent: begin
                    if (outAck) begin
                        state <= cdcLinkPkg::hsRelease;  // Consumer took it
                    end
                end
                cdcLinkPkg::hsRelease: begin
                    if (!outAck) begin
                        state <= cdcLinkPkg::hsIdle;     // Four phases done
                    end
                end
                default: begin
                    state <= cdcLinkPkg::hsIdle;  // Unused encoding
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/cdcLink.sv
/* CDC link top level */

`timescale 1ns/100ps
`default_nettype none

module cdcLink #(
    parameter int Depth = 8  // FIFO entries
) (
    input wire arok,
    // Producer side
    input wire wclk,
    input wire inReq,
    input wire cdcLinkPkg::linkWordT inWord,
    output logic inAck,
    // Consumer side
    input wire rclk,
    output logic outReq,
    output cdcLinkPkg::linkWordT outWord,
    input wire outAck
);

    logic push, full;   // wclk domain
    logic pop, empty;   // rclk domain
    cdcLinkPkg::linkWordT pushWord, headWord;

    // ====================
    // Write, FIFO, read
    // ====================
    writeAdapter writeSide (
        .wclk(wclk), .arok(arok),
        .inReq(inReq), .inWord(inWord), .inAck(inAck),
        .full(full), .push(push), .pushWord(pushWord)
    );

    asyncFifo #(.Depth(Depth)) fifo (
        .wclk(wclk), .arok(arok), .push(push), .pushWord(pushWord), .full(full),
        .rclk(rclk), .pop(pop), .headWord(headWord), .empty(empty)
    );

    readAdapter readSide (
        .rclk(rclk), .arok(arok),
        .empty(empty), .headWord(headWord), .pop(pop),
        .outReq(outReq), .outWord(outWord), .outAck(outAck)
    );

endmodule

`default_nettype wire

// File: verification/cdcLinkChecker.sv
/* Link scoreboard */

`timescale 1ns/100ps
`default_nettype none

module cdcLinkChecker #(
    parameter int Depth = 8
) (
    input wire wclk,
    input wire rclk,
    input wire arok,
    input wire inReq,
    input wire inAck,
    input wire cdcLinkPkg::linkWordT inWord,
    input wire outReq,
    input wire outAck,
    input wire cdcLinkPkg::linkWordT outWord,
    input wire runDone,
    input int sentCount
);

    cdcLinkPkg::linkWordT expected [$];  // Accepted words, in order
    int acceptedCount = 0;    // wclk side
    int peak = 0;             // Most words held at once
    int writeProtoCount = 0;
    int capacityCount = 0;
    int consumedCount = 0;    // rclk side
    int receivedCount = 0;
    int mismatchCount = 0;
    int readProtoCount = 0;
    int otherCount = 0;
    int endCount = 0;         // End of run checks
    int sinceReset = 0;
    logic inReqPrev = 1'b0;
    logic inAckPrev = 1'b0;
    logic outReqPrev = 1'b0;
    logic outAckPrev = 1'b0;
    cdcLinkPkg::linkWordT inWordPrev = '0;

    // ====================
    // Producer side
    // ====================
    always @(posedge wclk) begin
        if (!arok && inAck) begin
            writeProtoCount++;
            $display("Reset state wrong: inAck high during reset");
        end
        if (arok && inAck && !inAckPrev) begin  // Rose at the previous edge
            if (!inReqPrev) begin
                writeProtoCount++;
                $display("Protocol error: inAck rose while inReq was low");
            end
            expected.push_back(inWordPrev);
            acceptedCount = acceptedCount + 1;
            if (acceptedCount - consumedCount > Depth + 1) begin
                capacityCount++;
                $display("Back-pressure failed: %0d words held, limit %0d",
                         acceptedCount - consumedCount, Depth + 1);
            end
            if (acceptedCount - consumedCount > peak) begin
                peak = acceptedCount - consumedCount;
            end
        end
        if (arok && !inAck && inAckPrev && inReqPrev) begin
            writeProtoCount++;
            $display("Protocol error: inAck fell while inReq was high");
        end
        inReqPrev = inReq;
        inAckPrev = inAck;
        inWordPrev = inWord;
    end

    // ====================
    // Consumer side
    // ====================
    always @(posedge rclk) begin
        if ((!arok || sinceReset < 2) && outReq) begin
            readProtoCount++;
            $display("Reset state wrong: outReq high during or just after reset");
        end
        sinceReset = arok ? sinceReset + 1 : 0;
        if (arok && outReq && !outReqPrev) begin  // New word presented
            if (receivedCount >= expected.size()) begin
                otherCount++;
                $display("Word %h presented although none was outstanding", outWord);
            end else if (outWord !== expected[receivedCount]) begin
                mismatchCount++;
                $display("mismatch inOrderDelivery word %0d expected %h actual %h",
                         receivedCount, expected[receivedCount], outWord);
            end
            receivedCount++;
        end
        if (arok && !outReq && outReqPrev && !outAckPrev) begin
            readProtoCount++;
            $display("Protocol error: outReq fell before outAck rose");
        end
        if (arok && outAck && !outAckPrev) begin
            consumedCount <= consumedCount + 1;  // Word leaves the link
        end
        outReqPrev = outReq;
        outAckPrev = outAck;
    end

    // Totals once both drivers are done
    always @(posedge runDone) begin
        if (receivedCount != sentCount || acceptedCount != sentCount) begin
            endCount++;
            $display("Word count wrong: sent %0d, accepted %0d, received %0d",
                     sentCount, acceptedCount, receivedCount);
        end
        if (peak != Depth + 1) begin
            endCount++;
            $display("Back-pressure not reached: at most %0d words held, expected %0d",
                     peak, Depth + 1);
        end
    end

endmodule

`default_nettype wire

// File: verification/cdcLinkProperties.sv
/* Link assertions */

`timescale 1ns/100ps
`default_nettype none

module cdcLinkProperties #(
    parameter int Depth = 8
) (
    input wire wclk,
    input wire rclk,
    input wire arok,
    input wire push,
    input wire pop,
    input wire outReq,
    input wire outAck,
    input wire cdcLinkPkg::linkWordT outWord
);

    int pushCount;  // Words written since reset
    int popCount;   // Words read since reset

    always @(posedge wclk or negedge arok) begin
        if (!arok) begin
            pushCount <= 0;
        end else if (push) begin
            pushCount <= pushCount + 1;
        end
    end

    always @(posedge rclk or negedge arok) begin
        if (!arok) begin
            popCount <= 0;
        end else if (pop) begin
            popCount <= popCount + 1;
        end
    end

    // ====================
    // FIFO flags
    // ====================
    // Full must hold off a write once Depth words are stored
    overflowGuard: assert property (@(posedge wclk) disable iff (!arok)
        push |-> pushCount - popCount < Depth)
        else $error("push issued while the FIFO already held Depth words");

    // Empty must hold off a read until a word is stored
    underflowGuard: assert property (@(posedge rclk) disable iff (!arok)
        pop |-> pushCount > popCount)
        else $error("pop issued while the FIFO held no word");

    // ====================
    // Consumer handshake
    // ====================
    reqHold: assert property (@(posedge rclk) disable iff (!arok)
        outReq && !outAck |=> outReq)
        else $error("outReq fell before outAck rose");

    // Word held for the whole request phase
    wordStable: assert property (@(posedge rclk) disable iff (!arok)
        outReq && $past(outReq) |-> $stable(outWord))
        else $error("outWord changed while outReq was high");

endmodule

// Top level sees both FIFO ports and the consumer handshake together
bind cdcLink cdcLinkProperties #(.Depth(Depth)) props (
    .wclk(wclk), .rclk(rclk), .arok(arok),
    .push(push), .pop(pop),
    .outReq(outReq), .outAck(outAck), .outWord(outWord)
);

`default_nettype wire

// File: verification/cdcLinkTb.sv
/* CDC link testbench */

`timescale 1ns/100ps
`default_nettype none

module cdcLinkTb;

    localparam int Depth = 8;

    logic rclk, wclk, arok;
    logic inReq, inAck, outReq, outAck;
    logic runDone = 1'b0;
    cdcLinkPkg::linkWordT inWord, outWord;

    cdcLinkPkg::linkWordT words [$];  // Stimulus table
    int prodIdle [$];
    int consDelay [$];
    int wordCount = 0;
    int maxDelay = 0;
    int loadErrors = 0;
    int seed = 32'h90d8;
    bit loaded = 1'b0;
    int errorTotal;

    cdcLink #(.Depth(Depth)) dut (
        .arok(arok), .wclk(wclk), .inReq(inReq), .inWord(inWord), .inAck(inAck),
        .rclk(rclk), .outReq(outReq), .outWord(outWord), .outAck(outAck)
    );

    cdcLinkChecker #(.Depth(Depth)) linkCheck (
        .wclk(wclk), .rclk(rclk), .arok(arok),
        .inReq(inReq), .inAck(inAck), .inWord(inWord),
        .outReq(outReq), .outAck(outAck), .outWord(outWord),
        .runDone(runDone), .sentCount(wordCount)
    );

    // ====================
    // Clocks
    // ====================
    initial begin
        rclk = 1'b0;
        forever #50 rclk = ~rclk;  // 100 ns
    end

    initial begin
        wclk = 1'b0;
        forever #35 wclk = ~wclk;  // 70 ns, drifts against rclk
    end

    // ff in a delay column means random 0 to 7
    function automatic int resolveDelay(input int field);
        if (field == 'hff) begin
            return $unsigned($random(seed)) % 8;
        end
        return field;
    endfunction

    task automatic readStimulus();
        int fd;
        int fields;
        int idle;
        int delay;
        string line;
        cdcLinkPkg::linkWordT word;
        fd = $fopen("verification/cdcLinkStimulus.txt", "r");
        if (fd == 0) begin
            loadErrors++;
            $display("Cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) break;
                fields = $sscanf(line, "%h %h %h", word, idle, delay);
                if (fields == 3) begin  // Comment lines give no fields
                    words.push_back(word);
                    prodIdle.push_back(resolveDelay(idle));
                    consDelay.push_back(resolveDelay(delay));
                    maxDelay = (prodIdle[$] > maxDelay) ? prodIdle[$] : maxDelay;
                    maxDelay = (consDelay[$] > maxDelay) ? consDelay[$] : maxDelay;
                end
            end
            $fclose(fd);
        end
        wordCount = words.size();
        if (wordCount == 0) begin
            loadErrors++;
            $display("Stimulus file holds no words");
        end
    endtask

    // ====================
    // Drivers
    // ====================
    task automatic produceWords();
        for (int i = 0; i < wordCount; i++) begin
            repeat (prodIdle[i]) @(negedge wclk);
            @(negedge wclk);
            inWord = words[i];
            inReq = 1'b1;
            do @(negedge wclk); while (!inAck);
            inReq = 1'b0;
            do @(negedge wclk); while (inAck);  // Return to zero
        end
    endtask

    task automatic consumeWords();
        for (int i = 0; i < wordCount; i++) begin
            do @(negedge rclk); while (!outReq);
            repeat (consDelay[i]) @(negedge rclk);
            outAck = 1'b1;
            do @(negedge rclk); while (outReq);
            outAck = 1'b0;
        end
    endtask

    initial begin
        arok = 1'b0;
        inReq = 1'b0;
        outAck = 1'b0;
        inWord = '0;
        readStimulus();
        loaded = 1'b1;
        repeat (10) @(posedge rclk);
        @(negedge rclk);
        arok = 1'b1;
        fork
            produceWords();
            consumeWords();
        join
        repeat (4) @(negedge rclk);  // Last handshake settles
        runDone = 1'b1;
        @(negedge rclk);
        errorTotal = linkCheck.mismatchCount + linkCheck.writeProtoCount
                   + linkCheck.readProtoCount + linkCheck.capacityCount
                   + linkCheck.otherCount + linkCheck.endCount + loadErrors;
        $display("Errors: %0d mismatch, %0d protocol, %0d capacity, %0d other",
                 linkCheck.mismatchCount,
                 linkCheck.writeProtoCount + linkCheck.readProtoCount,
                 linkCheck.capacityCount,
                 linkCheck.otherCount + linkCheck.endCount + loadErrors);
        if (errorTotal == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog scaled by word count and longest delay
    initial begin
        longint limitNs;
        wait (loaded);
        limitNs = longint'(wordCount + 1) * (20 + maxDelay) * 100;
        #(limitNs);
        $display("Timeout: the handshakes did not finish within %0d ns", limitNs);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/cdcLinkPkg.sv
hw/asyncFifo.sv
hw/writeAdapter.sv
hw/readAdapter.sv
hw/cdcLink.sv
verification/cdcLinkChecker.sv
verification/cdcLinkProperties.sv
verification/cdcLinkTb.sv

// File: Makefile
# Verilator build and run of the CDC link testbench

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module cdcLinkTb -f verilog.f
	./obj_dir/VcdcLinkTb | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/cdcLinkStimulus.txt
// word prodIdle consDelay, all hex; ff draws a random delay of 0 to 7
// word 5 stalls the consumer so the FIFO fills up behind it
0a11 00 00
1122 02 01
2233 00 00
3344 05 03
4455 00 00
5566 00 40
6677 00 00
7788 00 00
8899 00 00
99aa 00 00
aabb 00 00
bbcc 00 00
ccdd 00 00
ddee 00 00
eeff 00 00
f001 01 00
0112 ff ff
1223 ff ff
2334 00 ff
3445 ff 00
4556 ff ff
5667 03 ff
6778 ff 02
7889 ff ff
899a 00 00
9aab ff ff
